//--- lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// clock cycles per microsecond kept small for short simulations
`define LCD_CLK_PER_US 3

// init sequence timing in microseconds
`define LCD_POWERUP_US 500     // wait after power is applied
`define LCD_CMD_PULSE_US 10    // e high time per init command
`define LCD_WAIT_SHORT_US 50   // after function set and display control
`define LCD_WAIT_CLEAR_US 200  // clear display is the slow one
`define LCD_WAIT_ENTRY_US 100  // after entry mode set

// run-time bus cycle in microseconds
`define LCD_CYCLE_US 50        // whole transfer
`define LCD_E_RISE_US 1        // setup before e rises
`define LCD_E_FALL_US 14       // e falls here

// must hold the power-up count
`define LCD_CNT_BITS 11

`endif

//--- lcd_pkg.sv
package lcd_pkg;

	// controller phases
	typedef enum logic [1:0] {
		POWERUP,
		INIT,
		IDLE,
		XFER
	} lcd_ctrl_state_t;

	// position in the init command list
	typedef enum logic [2:0] {
		FUNC_SET,
		DISP_CTRL,
		CLEAR,
		ENTRY_MODE,
		DONE
	} lcd_init_step_t;

	// command prefixes that the option bits get or-ed into
	typedef enum logic [7:0] {
		CMD_CLEAR     = 8'h01,
		CMD_ENTRY     = 8'h04,
		CMD_DISPLAY   = 8'h08,
		CMD_FUNCTION  = 8'h30,  // includes the 8-bit interface bit
		CMD_SET_DDRAM = 8'h80
	} lcd_opcode_t;

	typedef enum logic [2:0] {
		WAIT_INIT,
		READY,
		SEND_ADDR,
		SEND_DATA,
		SEND_CLEAR
	} lcd_writer_state_t;

	// 10-bit bus word with rs and rw above the data byte
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_bus_t;

endpackage

//--- lcd_controller.sv
`timescale 1ns/1ps
`include "lcd_config.svh"

module lcd_controller import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [6:0] init_flags,
	input  logic       xfer_start,
	input  lcd_bus_t   xfer_word,
	output logic       busy,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	typedef logic [`LCD_CNT_BITS-1:0] cnt_t;

	localparam int N = `LCD_CLK_PER_US;

	localparam cnt_t POWERUP_LAST = cnt_t'(`LCD_POWERUP_US * N - 1);
	localparam cnt_t PULSE_LAST   = cnt_t'(`LCD_CMD_PULSE_US * N - 1);
	localparam cnt_t SHORT_LAST   = cnt_t'((`LCD_CMD_PULSE_US + `LCD_WAIT_SHORT_US) * N - 1);
	localparam cnt_t CLEAR_LAST   = cnt_t'((`LCD_CMD_PULSE_US + `LCD_WAIT_CLEAR_US) * N - 1);
	localparam cnt_t ENTRY_LAST   = cnt_t'((`LCD_CMD_PULSE_US + `LCD_WAIT_ENTRY_US) * N - 1);
	localparam cnt_t CYCLE_LAST   = cnt_t'(`LCD_CYCLE_US * N - 1);
	localparam cnt_t E_RISE_LAST  = cnt_t'(`LCD_E_RISE_US * N - 1);
	localparam cnt_t E_FALL_LAST  = cnt_t'(`LCD_E_FALL_US * N - 1);

	lcd_ctrl_state_t state;
	lcd_init_step_t  step;
	cnt_t            cnt;     // shared by every phase
	lcd_bus_t        bus_q;   // registered pin word

	assign rs       = bus_q.rs;
	assign rw       = bus_q.rw;
	assign lcd_data = bus_q.data;

	// command byte for an init step with option bits from the flags
	function automatic logic [7:0] init_word(input lcd_init_step_t s, input logic [6:0] f);
		logic [7:0] w;
		case (s)
			FUNC_SET:   w = CMD_FUNCTION | {4'b0000, f[6], f[5], 2'b00};
			DISP_CTRL:  w = CMD_DISPLAY | {5'b00000, f[4], f[3], f[2]};
			CLEAR:      w = CMD_CLEAR;
			ENTRY_MODE: w = CMD_ENTRY | {6'b000000, f[1], f[0]};
			default:    w = 8'h00;
		endcase
		return w;
	endfunction

	// last count of a step covering the pulse and that command's wait
	function automatic cnt_t step_last(input lcd_init_step_t s);
		cnt_t c;
		case (s)
			FUNC_SET,
			DISP_CTRL:  c = SHORT_LAST;
			CLEAR:      c = CLEAR_LAST;
			ENTRY_MODE: c = ENTRY_LAST;
			default:    c = '0;
		endcase
		return c;
	endfunction

	function automatic lcd_init_step_t next_step(input lcd_init_step_t s);
		lcd_init_step_t n;
		case (s)
			FUNC_SET:   n = DISP_CTRL;
			DISP_CTRL:  n = CLEAR;
			CLEAR:      n = ENTRY_MODE;
			default:    n = DONE;
		endcase
		return n;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= POWERUP;
			step  <= FUNC_SET;
			cnt   <= '0;
			busy  <= 1'b1;
			e     <= 1'b0;
			bus_q <= '0;
		end else begin
			case (state)
				POWERUP: begin
					if (cnt == POWERUP_LAST) begin  // display has powered up
						cnt   <= '0;
						state <= INIT;
						step  <= FUNC_SET;
						e     <= 1'b1;
						bus_q <= '{rs: 1'b0, rw: 1'b0, data: init_word(FUNC_SET, init_flags)};
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				INIT: begin
					if (cnt == PULSE_LAST)
						e <= 1'b0;  // end of command pulse with the word held through the wait
					if (cnt == step_last(step)) begin
						cnt <= '0;
						if (step == ENTRY_MODE) begin
							state <= IDLE;
							step  <= DONE;
							busy  <= 1'b0;
							bus_q <= '0;
						end else begin
							step  <= next_step(step);
							e     <= 1'b1;
							bus_q <= '{rs: 1'b0, rw: 1'b0,
								data: init_word(next_step(step), init_flags)};
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				IDLE: begin
					if (xfer_start) begin
						state <= XFER;
						busy  <= 1'b1;
						cnt   <= '0;
						bus_q <= xfer_word;  // held for the whole cycle
					end
				end
				XFER: begin
					// e is high for counts e_rise..e_fall-1 of the cycle
					e <= (cnt >= E_RISE_LAST) && (cnt < E_FALL_LAST);
					if (cnt == CYCLE_LAST) begin
						state <= IDLE;
						busy  <= 1'b0;
						cnt   <= '0;
						bus_q <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= POWERUP;
			endcase
		end
	end

	a_no_e_idle: assert property (@(posedge clk) disable iff (reset)
		state == IDLE |-> !e)
		else $error("e high while idle");

	a_busy_state: assert property (@(posedge clk) disable iff (reset)
		busy == (state != IDLE))
		else $error("busy does not match state");

	// the writer must wait for idle before starting
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		xfer_start |-> !busy)
		else $error("xfer_start while busy");

endmodule

//--- lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       put_char,
	input  logic [7:0] char_code,
	input  logic       row,
	input  logic [3:0] col,
	input  logic       clear,
	input  logic       busy,
	output logic       ready,
	output logic       xfer_start,
	output lcd_bus_t   xfer_word
);

	lcd_writer_state_t state;
	logic              issued;    // start sent and not yet finished
	lcd_bus_t          pending;   // address or clear word
	logic [7:0]        char_q;
	logic              can_start;
	logic              xfer_done;

	assign ready = (state == READY);

	// controller free and nothing outstanding
	assign can_start = !issued && !busy;

	// start still visible in the cycle before busy rises
	assign xfer_done = issued && !xfer_start && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= WAIT_INIT;
			issued     <= 1'b0;
			xfer_start <= 1'b0;
		end else begin
			xfer_start <= 1'b0;  // one cycle strobe
			case (state)
				WAIT_INIT: begin
					if (!busy)
						state <= READY;  // controller finished init
				end
				READY: begin
					issued <= 1'b0;
					if (put_char)
						state <= SEND_ADDR;
					else if (clear)
						state <= SEND_CLEAR;
				end
				SEND_ADDR: begin
					if (can_start) begin
						xfer_start <= 1'b1;
						issued     <= 1'b1;
					end else if (xfer_done) begin
						issued <= 1'b0;
						state  <= SEND_DATA;  // data goes right behind the address
					end
				end
				SEND_DATA,
				SEND_CLEAR: begin
					if (can_start) begin
						xfer_start <= 1'b1;
						issued     <= 1'b1;
					end else if (xfer_done) begin
						issued <= 1'b0;
						state  <= READY;
					end
				end
				default: state <= WAIT_INIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ready && put_char) begin
			// ddram address with the second line at 0x40
			pending <= '{rs: 1'b0, rw: 1'b0,
				data: CMD_SET_DDRAM | {1'b0, row, 2'b00, col}};
			char_q  <= char_code;
		end else if (ready && clear) begin
			pending <= '{rs: 1'b0, rw: 1'b0, data: CMD_CLEAR};
		end
		if (can_start && state == SEND_DATA)
			xfer_word <= '{rs: 1'b1, rw: 1'b0, data: char_q};
		else if (can_start && (state == SEND_ADDR || state == SEND_CLEAR))
			xfer_word <= pending;
	end

	a_one_request: assert property (@(posedge clk) disable iff (reset)
		ready |-> !(put_char && clear))
		else $error("put_char and clear together");

endmodule

//--- lcd_top.sv
`timescale 1ns/1ps

module lcd_top import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [6:0] init_flags,
	input  logic       put_char,
	input  logic [7:0] char_code,
	input  logic       row,
	input  logic [3:0] col,
	input  logic       clear,
	output logic       ready,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	logic     xfer_start;
	lcd_bus_t xfer_word;
	logic     busy;

	lcd_text_writer u_writer (
		.clk        (clk),
		.reset      (reset),
		.put_char   (put_char),
		.char_code  (char_code),
		.row        (row),
		.col        (col),
		.clear      (clear),
		.busy       (busy),
		.ready      (ready),
		.xfer_start (xfer_start),
		.xfer_word  (xfer_word)
	);

	lcd_controller u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.init_flags (init_flags),
		.xfer_start (xfer_start),
		.xfer_word  (xfer_word),
		.busy       (busy),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data)
	);

endmodule

//--- lcd_tb.sv
`timescale 1ns/1ps
`include "lcd_config.svh"

module lcd_tb import lcd_pkg::*; ();

	localparam int N           = `LCD_CLK_PER_US;
	localparam int POWERUP_CYC = `LCD_POWERUP_US * N;
	localparam int INIT_WIDTH  = `LCD_CMD_PULSE_US * N;
	localparam int RUN_WIDTH   = (`LCD_E_FALL_US - `LCD_E_RISE_US) * N;
	localparam int INIT_CYC    = (4 * `LCD_CMD_PULSE_US + 2 * `LCD_WAIT_SHORT_US
		+ `LCD_WAIT_CLEAR_US + `LCD_WAIT_ENTRY_US) * N;
	localparam int CHAR_COUNT  = 50;
	localparam int MAX_CLEARS  = 12;
	localparam int MAX_REQ     = CHAR_COUNT + MAX_CLEARS + 2;  // room for a stray accept
	localparam int REQ_CYC     = (2 * `LCD_CYCLE_US + 10) * N;
	localparam int TIMEOUT_CYC = POWERUP_CYC + INIT_CYC + MAX_REQ * REQ_CYC + 1000;

	localparam logic [1:0] K_INIT  = 2'd0;
	localparam logic [1:0] K_CHAR  = 2'd1;
	localparam logic [1:0] K_CLEAR = 2'd2;
	localparam logic [1:0] K_EXTRA = 2'd3;

	typedef struct packed {
		logic [1:0] kind;
		lcd_bus_t   word;
	} exp_word_t;

	logic       clk;
	logic       reset;
	logic [6:0] init_flags;
	logic       put_char;
	logic [7:0] char_code;
	logic       row;
	logic [3:0] col;
	logic       clear;
	logic       ready;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;

	integer    seed;
	exp_word_t exp_q[$];         // words the display should latch in order
	int        mon_errs[4];      // error count per kind from the pin model
	int        rw_errs     = 0;
	int        words_seen  = 0;
	int        chars_acc   = 0;
	int        clears_acc  = 0;
	int        stray_cnt   = 0;
	int        tests_run   = 0;
	int        tests_failed = 0;
	int        cycles      = 0;

	lcd_top UUT (
		.clk        (clk),
		.reset      (reset),
		.init_flags (init_flags),
		.put_char   (put_char),
		.char_code  (char_code),
		.row        (row),
		.col        (col),
		.clear      (clear),
		.ready      (ready),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic void expect_word(input logic [1:0] kind, input logic rs_bit,
		input logic [7:0] data);
		exp_word_t x;
		x.kind      = kind;
		x.word.rs   = rs_bit;
		x.word.rw   = 1'b0;
		x.word.data = data;
		exp_q.push_back(x);
	endfunction

	task automatic report_test(input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: FAIL, %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	// note what the writer took at this edge and drive the next strobe
	task automatic run_cycle(input logic active);
		logic strobed;
		int   pick;
		@(posedge clk);
		strobed = put_char || clear;
		if (put_char && ready) begin
			expect_word(K_CHAR, 1'b0, 8'h80 + (row ? 8'h40 : 8'h00) + {4'h0, col});
			expect_word(K_CHAR, 1'b1, char_code);
			chars_acc++;
		end else if (clear && ready) begin
			expect_word(K_CLEAR, 1'b0, 8'h01);
			clears_acc++;
		end else if (strobed) begin
			stray_cnt++;  // dropped by the writer
		end
		put_char <= 1'b0;
		clear    <= 1'b0;
		pick = $random(seed);
		if (active && ready && !strobed && pick[1:0] == 2'b00) begin
			if (pick[4:2] == 3'b000 && clears_acc < MAX_CLEARS) begin
				clear <= 1'b1;
			end else if (chars_acc < CHAR_COUNT) begin
				put_char  <= 1'b1;
				char_code <= pick[15:8];
				row       <= pick[16];
				col       <= pick[20:17];
			end
		end else if (active && !ready && pick[7:2] == 6'd0) begin
			if (pick[8]) begin
				clear <= 1'b1;
			end else begin
				put_char  <= 1'b1;
				char_code <= pick[15:8];
				row       <= pick[16];
				col       <= pick[20:17];
			end
		end
	endtask

	// display model latching the pins when e falls and timing e high
	always @(posedge clk) begin : pin_model
		exp_word_t x;
		int        exp_width;
		logic      e_prev;
		int        e_width;
		if (reset) begin
			e_prev  = 1'b0;
			e_width = 0;
		end else begin
			if (rw !== 1'b0) begin
				$display("mismatch at %0t: rw expected 0 got %b", $time, rw);
				rw_errs++;
			end
			if (e_prev && !e) begin
				if (exp_q.size() == 0) begin
					$display("at %0t the display latched %h with no request behind it",
						$time, lcd_data);
					mon_errs[K_EXTRA]++;
				end else begin
					x = exp_q.pop_front();
					exp_width = (x.kind == K_INIT) ? INIT_WIDTH : RUN_WIDTH;
					if (lcd_data !== x.word.data) begin
						$display("mismatch at %0t: lcd_data expected %h got %h",
							$time, x.word.data, lcd_data);
						mon_errs[x.kind]++;
					end
					if (rs !== x.word.rs) begin
						$display("mismatch at %0t: rs expected %b got %b", $time, x.word.rs, rs);
						mon_errs[x.kind]++;
					end
					if (e_width != exp_width) begin
						$display("mismatch at %0t: e width expected %0d got %0d",
							$time, exp_width, e_width);
						mon_errs[x.kind]++;
					end
				end
				words_seen++;
				e_width = 0;
			end
			if (e)
				e_width++;
			e_prev = e;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		int errs;
		seed      = 32'hc2a8;
		reset     = 1'b1;
		put_char  = 1'b0;
		char_code = 8'h00;
		row       = 1'b0;
		col       = 4'h0;
		clear     = 1'b0;
		for (int i = 0; i < 4; i++)
			mon_errs[i] = 0;
		init_flags = 7'($random(seed));
		// HD44780 init commands with the option bits in place
		expect_word(K_INIT, 1'b0, {4'b0011, init_flags[6], init_flags[5], 2'b00});
		expect_word(K_INIT, 1'b0, {5'b00001, init_flags[4], init_flags[3], init_flags[2]});
		expect_word(K_INIT, 1'b0, 8'h01);
		expect_word(K_INIT, 1'b0, {6'b000001, init_flags[1], init_flags[0]});
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		errs = 0;
		repeat (POWERUP_CYC) begin
			run_cycle(1'b1);  // only strays while ready is low
			if (e !== 1'b0) begin
				$display("mismatch at %0t: e expected 0 got %b", $time, e);
				errs++;
			end
			if (ready !== 1'b0) begin
				$display("mismatch at %0t: ready expected 0 got %b", $time, ready);
				errs++;
			end
		end
		report_test("power-up", errs);

		while (ready !== 1'b1)
			run_cycle(1'b0);
		errs = mon_errs[K_INIT];
		if (words_seen != 4) begin
			$display("mismatch at %0t: init word count expected 4 got %0d",
				$time, words_seen);
			errs++;
		end
		report_test("init sequence", errs);

		while (chars_acc < CHAR_COUNT)
			run_cycle(1'b1);
		do
			run_cycle(1'b0);
		while (ready !== 1'b1);
		repeat (10) run_cycle(1'b0);

		report_test("random characters", mon_errs[K_CHAR]);

		errs = mon_errs[K_CLEAR];
		if (clears_acc == 0) begin
			$display("no clear request was accepted during the run");
			errs++;
		end
		report_test("random clears", errs);

		errs = rw_errs + mon_errs[K_EXTRA];
		if (words_seen != 4 + 2 * chars_acc + clears_acc) begin
			$display("mismatch at %0t: word count expected %0d got %0d",
				$time, 4 + 2 * chars_acc + clears_acc, words_seen);
			errs++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected words never reached the display", exp_q.size());
			errs++;
		end
		if (stray_cnt == 0) begin
			$display("no strobe was driven while ready was low");
			errs++;
		end
		report_test("ignored strobes", errs);

		$display("tests run %0d, passed %0d, failed %0d (%0d chars, %0d clears, %0d strays)",
			tests_run, tests_run - tests_failed, tests_failed, chars_acc, clears_acc, stray_cnt);
		if (tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
lcd_pkg.sv
lcd_controller.sv
lcd_text_writer.sv
lcd_top.sv
lcd_tb.sv

//--- Bender.yml
package:
  name: lcd_subsystem

sources:
  - include_dirs:
      - .
    files:
      - lcd_pkg.sv
      - lcd_controller.sv
      - lcd_text_writer.sv
      - lcd_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - lcd_tb.sv
